// ==== logic/commit_pkg.sv ====
`default_nettype none

package commit_pkg;

    // datapath and queue sizing
    localparam int unsigned XLEN        = 32;
    localparam int unsigned AREG_W      = 5;
    localparam int unsigned ROB_DEPTH   = 8;
    localparam int unsigned ROB_PTR_W   = 3;  // log2 of ROB_DEPTH
    localparam int unsigned MEM_AW      = 8;
    localparam int unsigned LSU_LATENCY = 3;  // first request cycle to done pulse

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [AREG_W-1:0]    areg_t;
    typedef logic [MEM_AW-1:0]    maddr_t;
    typedef logic [ROB_PTR_W-1:0] rob_ptr_t;

    // instruction kinds seen at retirement
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_SERIAL = 2'd1,  // plain write-back, slot 0 only
        OP_ULOAD  = 2'd2,
        OP_USTORE = 2'd3
    } inst_op_e;

    // retire engine FSM
    typedef enum logic [1:0] {
        S_NORMAL      = 2'd0,
        S_WAIT_ULOAD  = 2'd1,  // load result replaces slot 0 data, then flush
        S_WAIT_USTORE = 2'd2,
        S_WAIT_FLUSH  = 2'd3   // drop younger work until the queue drains
    } commit_state_e;

endpackage

`default_nettype wire

// ==== logic/rob_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_queue (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    // dispatch side
    input  wire logic                    alloc_valid_i,
    input  commit_pkg::inst_op_e         alloc_op_i,
    input  commit_pkg::areg_t            alloc_wreg_i,
    input  commit_pkg::word_t            alloc_wdata_i,
    input  commit_pkg::maddr_t           alloc_addr_i,
    output logic                         alloc_ready_o,
    // retire side
    output logic                   [1:0] head_valid_o,
    output commit_pkg::inst_op_e   [1:0] head_op_o,
    output commit_pkg::areg_t      [1:0] head_wreg_o,
    output commit_pkg::word_t      [1:0] head_wdata_o,
    output commit_pkg::maddr_t     [1:0] head_addr_o,
    input  wire logic              [1:0] deq_i,
    input  wire logic                    flush_i,
    output logic                         empty_o
);

    import commit_pkg::*;

    // entry storage, no reset needed
    inst_op_e op_mem    [ROB_DEPTH];
    areg_t    wreg_mem  [ROB_DEPTH];
    word_t    wdata_mem [ROB_DEPTH];
    maddr_t   addr_mem  [ROB_DEPTH];

    rob_ptr_t           head_q;
    rob_ptr_t           tail_q;
    logic [ROB_PTR_W:0] count_q;  // one extra bit to tell full from empty

    logic               full;
    logic               wr_en;
    logic [1:0]         deq_cnt;
    rob_ptr_t [1:0]     head_idx;

    assign full          = count_q == (ROB_PTR_W + 1)'(ROB_DEPTH);
    assign empty_o       = count_q == '0;
    assign alloc_ready_o = !full && !flush_i;
    assign wr_en         = alloc_valid_i && alloc_ready_o;
    assign deq_cnt       = {1'b0, deq_i[0]} + {1'b0, deq_i[1]};

    assign head_idx[0] = head_q;
    assign head_idx[1] = head_q + rob_ptr_t'(1);  // wraps, depth is a power of two

    // two oldest entries
    always_comb begin
        head_valid_o[0] = count_q != '0;
        head_valid_o[1] = count_q > (ROB_PTR_W + 1)'(1);
        for (int i = 0; i < 2; i++) begin
            head_op_o[i]    = op_mem[head_idx[i]];
            head_wreg_o[i]  = wreg_mem[head_idx[i]];
            head_wdata_o[i] = wdata_mem[head_idx[i]];
            head_addr_o[i]  = addr_mem[head_idx[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            op_mem[tail_q]    <= alloc_op_i;
            wreg_mem[tail_q]  <= alloc_wreg_i;
            wdata_mem[tail_q] <= alloc_wdata_i;
            addr_mem[tail_q]  <= alloc_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // everything still queued is younger than the flushing load
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (wr_en) begin
                tail_q <= tail_q + rob_ptr_t'(1);
            end
            head_q  <= head_q + rob_ptr_t'(deq_cnt);
            count_q <= count_q + (ROB_PTR_W + 1)'(wr_en) - (ROB_PTR_W + 1)'(deq_cnt);
        end
    end

    // retire engine pops only what is offered
    deq_within_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        (deq_i & ~head_valid_o) == 2'b00
    );

    // a full queue takes nothing, so count stays within depth and matches the pointers
    no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        count_q <= (ROB_PTR_W + 1)'(ROB_DEPTH)
        && tail_q == head_q + count_q[ROB_PTR_W-1:0]
    );

endmodule

`default_nettype wire

// ==== logic/uncached_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module uncached_port (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         req_i,    // level, held until done_o
    input  wire logic         write_i,
    input  commit_pkg::maddr_t addr_i,
    input  commit_pkg::word_t  wdata_i,
    output logic              done_o,   // one-cycle pulse
    output commit_pkg::word_t rdata_o
);

    import commit_pkg::*;

    localparam int unsigned MEM_WORDS = 2 ** MEM_AW;

    word_t mem [MEM_WORDS];

    logic [$clog2(LSU_LATENCY)-1:0] lat_cnt_q;  // cycles the request has waited
    logic                           done_q;
    word_t                          rdata_q;
    logic                           last_cycle;

    assign last_cycle = req_i && !done_q
                        && lat_cnt_q == ($clog2(LSU_LATENCY))'(LSU_LATENCY - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lat_cnt_q <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (last_cycle) begin
                lat_cnt_q <= '0;
                done_q    <= 1'b1;
            end else if (req_i && !done_q) begin
                lat_cnt_q <= lat_cnt_q + 1'b1;
            end
        end
    end

    // backing store, starts out as zeros
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (last_cycle && write_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (last_cycle && !write_i) begin
            rdata_q <= mem[addr_i];
        end
    end

    assign done_o  = done_q;
    assign rdata_o = rdata_q;

    // requester keeps asking until answered
    req_held_until_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_i && !done_o |=> req_i
    );

endmodule

`default_nettype wire

// ==== logic/retire_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_engine (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    // queue head
    input  wire logic              [1:0] head_valid_i,
    input  commit_pkg::inst_op_e   [1:0] head_op_i,
    input  commit_pkg::areg_t      [1:0] head_wreg_i,
    input  commit_pkg::word_t      [1:0] head_wdata_i,
    input  commit_pkg::maddr_t     [1:0] head_addr_i,
    input  wire logic                    empty_i,
    output logic                   [1:0] deq_o,
    output logic                         flush_o,
    // uncached port
    output logic                         lsu_req_o,
    output logic                         lsu_write_o,
    output commit_pkg::maddr_t           lsu_addr_o,
    output commit_pkg::word_t            lsu_wdata_o,
    input  wire logic                    lsu_done_i,
    input  commit_pkg::word_t            lsu_rdata_i,
    // retirement
    output logic                   [1:0] retire_o,
    output logic                   [1:0] commit_o,
    output commit_pkg::areg_t      [1:0] wreg_o,
    output commit_pkg::word_t      [1:0] wdata_o
);

    import commit_pkg::*;

    commit_state_e state_q;
    commit_state_e state_d;

    logic        h_ready;  // H takes a new pair this cycle
    logic        f_block;
    logic        pair_ok;
    logic  [1:0] f_valid;

    // skid buffer between F and H; only slot 0 can be uncached
    logic        skid_ready_q;  // high while empty
    logic  [1:0] skid_valid_q;
    inst_op_e    skid_op_q;
    maddr_t      skid_addr_q;
    areg_t [1:0] skid_wreg_q;
    word_t [1:0] skid_wdata_q;

    // H stage inputs
    logic  [1:0] h_in_valid;
    inst_op_e    h_in_op;
    maddr_t      h_in_addr;
    areg_t [1:0] h_in_wreg;
    word_t [1:0] h_in_wdata;

    logic  [1:0] h_valid_q;
    inst_op_e    h_op_q;
    maddr_t      h_addr_q;
    areg_t [1:0] h_wreg_q;
    word_t [1:0] h_wdata_q;
    logic        h_uncached;

    logic  [1:0] retire_d;
    logic  [1:0] commit_d;
    word_t [1:0] wdata_d;
    logic        flush_d;
    logic        flush_q;

    // F stage: slot 1 only rides along as a plain ALU op on the other bank
    assign pair_ok = head_op_i[0] == OP_ALU && head_op_i[1] == OP_ALU
                     && head_wreg_i[0][0] != head_wreg_i[1][0];
    assign f_block = state_q == S_WAIT_FLUSH || flush_q;
    assign f_valid = {head_valid_i[1] && pair_ok, head_valid_i[0]} & {2{!f_block}};
    assign deq_o   = skid_ready_q ? f_valid : 2'b00;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            skid_ready_q <= 1'b1;
            skid_valid_q <= 2'b00;
        end else if (state_q == S_WAIT_FLUSH) begin
            skid_ready_q <= 1'b1;
            skid_valid_q <= 2'b00;
        end else if (skid_ready_q) begin
            if (!h_ready && |f_valid) begin
                skid_ready_q <= 1'b0;
                skid_valid_q <= f_valid;
            end
        end else if (h_ready) begin
            skid_ready_q <= 1'b1;
            skid_valid_q <= 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (skid_ready_q) begin
            skid_op_q    <= head_op_i[0];
            skid_addr_q  <= head_addr_i[0];
            skid_wreg_q  <= head_wreg_i;
            skid_wdata_q <= head_wdata_i;
        end
    end

    assign h_in_valid = skid_ready_q ? f_valid : skid_valid_q;
    assign h_in_op    = skid_ready_q ? head_op_i[0] : skid_op_q;
    assign h_in_addr  = skid_ready_q ? head_addr_i[0] : skid_addr_q;
    assign h_in_wreg  = skid_ready_q ? head_wreg_i : skid_wreg_q;
    assign h_in_wdata = skid_ready_q ? head_wdata_i : skid_wdata_q;

    // H stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_valid_q <= 2'b00;
        end else if (state_q == S_WAIT_FLUSH) begin
            h_valid_q <= 2'b00;  // younger than the load, dropped
        end else if (h_ready) begin
            h_valid_q <= h_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (h_ready) begin
            h_op_q    <= h_in_op;
            h_addr_q  <= h_in_addr;
            h_wreg_q  <= h_in_wreg;
            h_wdata_q <= h_in_wdata;
        end
    end

    assign h_uncached = h_op_q == OP_ULOAD || h_op_q == OP_USTORE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_NORMAL;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d  = state_q;
        h_ready  = 1'b1;
        retire_d = 2'b00;
        commit_d = 2'b00;
        flush_d  = 1'b0;
        wdata_d  = h_wdata_q;
        case (state_q)
            S_NORMAL: begin
                if (h_valid_q[0] && h_uncached) begin
                    h_ready = 1'b0;  // park in H, request goes out next cycle
                    state_d = (h_op_q == OP_USTORE) ? S_WAIT_USTORE : S_WAIT_ULOAD;
                end else begin
                    retire_d = h_valid_q;
                    commit_d = h_valid_q;
                end
            end
            S_WAIT_ULOAD: begin
                h_ready = lsu_done_i;
                if (lsu_done_i) begin
                    retire_d   = 2'b01;
                    commit_d   = 2'b01;
                    wdata_d[0] = lsu_rdata_i;
                    state_d    = S_WAIT_FLUSH;
                end
            end
            S_WAIT_USTORE: begin
                h_ready = lsu_done_i;
                if (lsu_done_i) begin
                    retire_d = 2'b01;  // stores write no register
                    state_d  = S_NORMAL;
                end
            end
            S_WAIT_FLUSH: begin
                flush_d = 1'b1;
                if (empty_i) begin
                    state_d = S_NORMAL;
                end
            end
            default: state_d = S_NORMAL;
        endcase
    end

    assign lsu_req_o   = state_q == S_WAIT_ULOAD || state_q == S_WAIT_USTORE;
    assign lsu_write_o = state_q == S_WAIT_USTORE;
    assign lsu_addr_o  = h_addr_q;
    assign lsu_wdata_o = h_wdata_q[0];

    // registered retire outputs
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_o <= 2'b00;
            commit_o <= 2'b00;
            flush_q  <= 1'b0;
        end else begin
            retire_o <= retire_d;
            commit_o <= commit_d;
            flush_q  <= flush_d;
        end
    end

    always_ff @(posedge clk) begin
        wreg_o  <= h_wreg_q;
        wdata_o <= wdata_d;
    end

    assign flush_o = flush_q;

    // the F stage bank check must still hold two stages later
    dual_commit_banks: assert property (
        @(posedge clk) disable iff (!rst_n)
        commit_o == 2'b11 |-> wreg_o[0][0] != wreg_o[1][0]
    );

endmodule

`default_nettype wire

// ==== logic/commit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_top (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                alloc_valid_i,
    input  commit_pkg::inst_op_e     alloc_op_i,
    input  commit_pkg::areg_t        alloc_wreg_i,
    input  commit_pkg::word_t        alloc_wdata_i,
    input  commit_pkg::maddr_t       alloc_addr_i,
    output logic                     alloc_ready_o,
    output logic               [1:0] retire_o,
    output logic               [1:0] commit_o,
    output commit_pkg::areg_t  [1:0] wreg_o,
    output commit_pkg::word_t  [1:0] wdata_o,
    output logic                     flush_o
);

    import commit_pkg::*;

    // queue head to engine
    logic     [1:0] head_valid;
    inst_op_e [1:0] head_op;
    areg_t    [1:0] head_wreg;
    word_t    [1:0] head_wdata;
    maddr_t   [1:0] head_addr;
    logic     [1:0] deq;
    logic           empty;

    // engine to uncached port
    logic           lsu_req;
    logic           lsu_write;
    maddr_t         lsu_addr;
    word_t          lsu_wdata;
    logic           lsu_done;
    word_t          lsu_rdata;

    rob_queue rob_queue_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_valid_i (alloc_valid_i),
        .alloc_op_i    (alloc_op_i),
        .alloc_wreg_i  (alloc_wreg_i),
        .alloc_wdata_i (alloc_wdata_i),
        .alloc_addr_i  (alloc_addr_i),
        .alloc_ready_o (alloc_ready_o),
        .head_valid_o  (head_valid),
        .head_op_o     (head_op),
        .head_wreg_o   (head_wreg),
        .head_wdata_o  (head_wdata),
        .head_addr_o   (head_addr),
        .deq_i         (deq),
        .flush_i       (flush_o),
        .empty_o       (empty)
    );

    uncached_port uncached_port_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (lsu_req),
        .write_i (lsu_write),
        .addr_i  (lsu_addr),
        .wdata_i (lsu_wdata),
        .done_o  (lsu_done),
        .rdata_o (lsu_rdata)
    );

    retire_engine retire_engine_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_valid_i (head_valid),
        .head_op_i    (head_op),
        .head_wreg_i  (head_wreg),
        .head_wdata_i (head_wdata),
        .head_addr_i  (head_addr),
        .empty_i      (empty),
        .deq_o        (deq),
        .flush_o      (flush_o),
        .lsu_req_o    (lsu_req),
        .lsu_write_o  (lsu_write),
        .lsu_addr_o   (lsu_addr),
        .lsu_wdata_o  (lsu_wdata),
        .lsu_done_i   (lsu_done),
        .lsu_rdata_i  (lsu_rdata),
        .retire_o     (retire_o),
        .commit_o     (commit_o),
        .wreg_o       (wreg_o),
        .wdata_o      (wdata_o)
    );

endmodule

`default_nettype wire

// ==== bench/commit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_tb;

    import commit_pkg::*;

    localparam int CLK_HALF     = 2;
    localparam int RST_CYCLES   = 8;
    localparam int WAIT_LIMIT   = 200;  // cycles for any single wait
    // rough test lengths in cycles
    localparam int ALU_CYCLES   = 60;
    localparam int PAIR_CYCLES  = 80;
    localparam int UNC_CYCLES   = 60;
    localparam int FLUSH_CYCLES = 80;
    localparam int BP_CYCLES    = 100;
    localparam int RUN_CYCLES   = RST_CYCLES + ALU_CYCLES + PAIR_CYCLES + UNC_CYCLES
                                  + FLUSH_CYCLES + BP_CYCLES;
    localparam int MARGIN       = 4;

    // one expected retirement
    typedef struct packed {
        logic     retire;
        logic     commit;
        inst_op_e op;
        areg_t    wreg;
        word_t    wdata;
    } expect_t;

    logic             clk;
    logic             rst_n;
    logic             alloc_valid_i;
    inst_op_e         alloc_op_i;
    areg_t            alloc_wreg_i;
    word_t            alloc_wdata_i;
    maddr_t           alloc_addr_i;
    logic             alloc_ready_o;
    logic       [1:0] retire_o;
    logic       [1:0] commit_o;
    areg_t      [1:0] wreg_o;
    word_t      [1:0] wdata_o;
    logic             flush_o;

    expect_t     sb [$];  // in allocation order
    word_t       mem_model [2**MEM_AW];
    logic [15:0] lfsr_q;
    string       cur_test;
    int          alloc_cnt;
    int          retire_cnt;
    int          pair_cnt;

    commit_top commit_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_valid_i (alloc_valid_i),
        .alloc_op_i    (alloc_op_i),
        .alloc_wreg_i  (alloc_wreg_i),
        .alloc_wdata_i (alloc_wdata_i),
        .alloc_addr_i  (alloc_addr_i),
        .alloc_ready_o (alloc_ready_o),
        .retire_o      (retire_o),
        .commit_o      (commit_o),
        .wreg_o        (wreg_o),
        .wdata_o       (wdata_o),
        .flush_o       (flush_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    initial begin
        repeat (RUN_CYCLES * MARGIN) @(posedge clk);
        report_failure("watchdog expired, the tests did not finish in time");
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s %s: expected %h, actual %h",
                                     cur_test, what, exp, act));
        end
    endtask

    task automatic check_reg(input string what, input areg_t exp, input areg_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s %s: expected %0d, actual %0d",
                                     cur_test, what, exp, act));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s %s: expected %b, actual %b",
                                     cur_test, what, exp, act));
        end
    endtask

    // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v[i]   = lfsr_q[0];
        end
    endtask

    // call on a falling edge, returns one cycle after the entry is written
    task automatic alloc_entry(input inst_op_e op, input areg_t wreg, input word_t wdata,
                               input maddr_t addr, input logic expected);
        expect_t e;
        int      waited;
        waited        = 0;
        alloc_valid_i = 1'b0;
        while (!alloc_ready_o) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure($sformatf("%s: alloc_ready_o stayed low", cur_test));
            end
        end
        alloc_valid_i = 1'b1;
        alloc_op_i    = op;
        alloc_wreg_i  = wreg;
        alloc_wdata_i = wdata;
        alloc_addr_i  = addr;
        alloc_cnt++;
        if (expected && op == OP_USTORE) begin
            mem_model[addr] = wdata;  // flushed stores never reach memory
        end
        e.retire = expected;  // low for entries a flush must drop
        e.commit = op != OP_USTORE;
        e.op     = op;
        e.wreg   = wreg;
        e.wdata  = (op == OP_ULOAD) ? mem_model[addr] : wdata;  // load returns memory
        sb.push_back(e);
        @(negedge clk);
        alloc_valid_i = 1'b0;
    endtask

    task automatic random_alu(input logic expected);
        word_t r;
        word_t d;
        take_bits(AREG_W, r);
        take_bits(XLEN, d);
        alloc_entry(OP_ALU, areg_t'(r), d, '0, expected);
    endtask

    task automatic random_uncached(input inst_op_e op, input maddr_t addr);
        word_t r;
        word_t d;
        take_bits(AREG_W, r);
        take_bits(XLEN, d);
        alloc_entry(op, areg_t'(r), d, addr, 1'b1);
    endtask

    task automatic compare_slot(input int s, input expect_t e);
        check_flag($sformatf("retire[%0d]", s), e.retire, retire_o[s]);
        check_flag($sformatf("commit[%0d]", s), e.commit, commit_o[s]);
        if (e.commit) begin  // stores leave wreg and wdata undefined
            check_reg($sformatf("wreg[%0d]", s), e.wreg, wreg_o[s]);
            check_word($sformatf("wdata[%0d]", s), e.wdata, wdata_o[s]);
        end
    endtask

    task automatic score_retirement();
        expect_t e0;
        expect_t e1;
        if (retire_o == 2'b10) begin
            report_failure($sformatf("%s: slot 1 retired without slot 0", cur_test));
        end
        if (sb.size() < (retire_o[1] ? 2 : 1)) begin
            report_failure($sformatf("%s: retirement with nothing left to expect", cur_test));
        end
        e0 = sb.pop_front();
        compare_slot(0, e0);
        if (retire_o[1]) begin
            e1 = sb.pop_front();
            if (e0.op != OP_ALU || e1.op != OP_ALU) begin
                report_failure($sformatf("%s: a non-ALU entry retired in a pair", cur_test));
            end
            if (e0.wreg[0] == e1.wreg[0]) begin
                report_failure($sformatf("%s: paired entries share a bank", cur_test));
            end
            compare_slot(1, e1);
            pair_cnt++;
        end
        retire_cnt += retire_o[1] ? 2 : 1;
    endtask

    // entries younger than the flushing load leave without a retire
    task automatic discard_flushed();
        while (sb.size() != 0 && !sb[0].retire) begin
            sb.delete(0);
        end
    endtask

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (rst_n && retire_o != 2'b00) begin
            score_retirement();
        end
        if (rst_n && flush_o) begin
            discard_flushed();
        end
    end

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (sb.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure($sformatf("%s: expected retirements never came", cur_test));
            end
        end
        repeat (8) @(negedge clk);  // quiet window, stray retires still get scored
    endtask

    task automatic wait_flush();
        int waited;
        waited = 0;
        while (!flush_o) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure($sformatf("%s: flush_o never rose", cur_test));
            end
        end
        waited = 0;
        while (flush_o) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure($sformatf("%s: flush_o never fell", cur_test));
            end
        end
    endtask

    task automatic reset_values_test();
        cur_test = "reset";
        for (int i = 0; i < 2; i++) begin
            check_flag($sformatf("retire[%0d]", i), 1'b0, retire_o[i]);
            check_flag($sformatf("commit[%0d]", i), 1'b0, commit_o[i]);
        end
        check_flag("flush", 1'b0, flush_o);
        check_flag("alloc_ready", 1'b1, alloc_ready_o);
    endtask

    task automatic alu_stream_test();
        cur_test = "alu_stream";
        repeat (20) random_alu(1'b1);
        wait_drain();
    endtask

    // stores stall the pipe so the queue backs up and pairs form
    task automatic pairing_test();
        word_t    k;
        word_t    r;
        word_t    d;
        inst_op_e op;
        cur_test = "pairing";
        pair_cnt = 0;
        for (int i = 0; i < 24; i++) begin
            if (i % 12 == 0) begin
                take_bits(MEM_AW, k);
                random_uncached(OP_USTORE, maddr_t'(k));
            end
            take_bits(2, k);
            take_bits(AREG_W, r);
            take_bits(XLEN, d);
            op = (k[1:0] == 2'b00) ? OP_SERIAL : OP_ALU;
            alloc_entry(op, areg_t'(r), d, '0, 1'b1);
        end
        wait_drain();
        if (pair_cnt == 0) begin
            report_failure("pairing: no paired retirement was seen");
        end
    endtask

    task automatic store_load_test();
        word_t a;
        cur_test = "store_load";
        take_bits(MEM_AW, a);
        random_uncached(OP_USTORE, maddr_t'(a));
        random_alu(1'b1);
        random_alu(1'b1);
        random_uncached(OP_ULOAD, maddr_t'(a));  // expects the stored word back
        wait_flush();
        wait_drain();
    endtask

    task automatic flush_test();
        word_t a;
        cur_test = "flush";
        take_bits(MEM_AW, a);
        random_uncached(OP_ULOAD, maddr_t'(a));
        repeat (5) random_alu(1'b0);  // younger than the load, must vanish
        wait_flush();
        repeat (6) random_alu(1'b1);
        wait_drain();
    endtask

    task automatic back_pressure_test();
        word_t a;
        int    base;
        int    held;
        cur_test = "back_pressure";
        base     = alloc_cnt - retire_cnt;  // entries dropped by earlier flushes
        take_bits(MEM_AW, a);
        random_uncached(OP_USTORE, maddr_t'(a));
        random_uncached(OP_USTORE, maddr_t'(a + 1));
        random_uncached(OP_ULOAD, maddr_t'(a));
        for (int i = 0; i < 3 * ROB_DEPTH && alloc_ready_o; i++) begin
            random_alu(1'b0);
        end
        if (alloc_ready_o) begin
            report_failure("back_pressure: alloc_ready_o never fell");
        end
        held = alloc_cnt - retire_cnt - base;
        if (held < int'(ROB_DEPTH)) begin
            report_failure($sformatf("back_pressure: ready fell with only %0d held", held));
        end
        wait_flush();
        wait_drain();
    endtask

    initial begin
        rst_n         = 1'b0;
        alloc_valid_i = 1'b0;
        alloc_op_i    = OP_ALU;
        alloc_wreg_i  = '0;
        alloc_wdata_i = '0;
        alloc_addr_i  = '0;
        lfsr_q        = 16'd98;
        alloc_cnt     = 0;
        retire_cnt    = 0;
        pair_cnt      = 0;
        cur_test      = "reset";
        for (int i = 0; i < 2**MEM_AW; i++) begin
            mem_model[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        reset_values_test();
        alu_stream_test();
        pairing_test();
        store_load_test();
        flush_test();
        back_pressure_test();
        if (sb.size() != 0) begin
            $display("%0d expected retirements are still outstanding", sb.size());
            $display("Test FAILED");
            $fatal(1, "stopped with work outstanding");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== commit_core.f ====
logic/commit_pkg.sv
logic/rob_queue.sv
logic/uncached_port.sv
logic/retire_engine.sv
logic/commit_top.sv
bench/commit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert --top-module commit_tb -f commit_core.f \
    -o commit_tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/commit_tb_sim > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0
